// File: common/ohci_pkg.sv
// ####################################################################
// OHCI list-service shared definitions: ED layout, register map and
// the structs between the register file and the list walker
// ####################################################################

package ohci_pkg;

  // ED pointer, byte address divided by 16
  typedef logic [27:0] ed_ptr_t;

  // Decoded endpoint descriptor
  typedef struct packed {
    logic    skip;
    logic    halted;
    ed_ptr_t head_ptr;
    ed_ptr_t tail_ptr;
    ed_ptr_t next_ed;
  } ed_t;

  // Register byte offsets
  localparam logic [7:0] CTRL_OFS      = 8'h00;
  localparam logic [7:0] STATUS_OFS    = 8'h04;
  localparam logic [7:0] CTRL_HEAD_OFS = 8'h08;
  localparam logic [7:0] CTRL_CUR_OFS  = 8'h0C;
  localparam logic [7:0] BULK_HEAD_OFS = 8'h10;
  localparam logic [7:0] BULK_CUR_OFS  = 8'h14;
  localparam logic [7:0] INTR_EN_OFS   = 8'h18;
  localparam logic [7:0] SERVICED_OFS  = 8'h1C;

  typedef struct packed {
    logic       run;
    logic       cle;
    logic       ble;
    logic [1:0] cbsr;
    ed_ptr_t    ctrl_head;
    ed_ptr_t    ctrl_cur;
    ed_ptr_t    bulk_head;
    ed_ptr_t    bulk_cur;
  } reg2hw_t;

  typedef struct packed {
    ed_ptr_t ctrl_cur_d;
    logic    ctrl_cur_de;
    ed_ptr_t bulk_cur_d;
    logic    bulk_cur_de;
    logic    run_clr;
    logic    done_set;
    logic    serviced_inc;
  } hw2reg_t;

endpackage

// File: common/ohci_desc_if.sv
// ####################################################################
// ED fetch channel between the list walker and the DMA reader
// ####################################################################

interface ohci_desc_if import ohci_pkg::*; ();

  logic    req_valid;
  logic    req_ready;
  ed_ptr_t req_addr;
  // One-cycle pulse per request
  logic    rsp_valid;
  ed_t     rsp_ed;
  logic    rsp_work;

  modport requester (
    output req_valid, req_addr,
    input  req_ready, rsp_valid, rsp_ed, rsp_work
  );

  modport responder (
    input  req_valid, req_addr,
    output req_ready, rsp_valid, rsp_ed, rsp_work
  );

endinterface

// File: dma/ohci_ed_unpack.sv
// ####################################################################
// Assembles an ED from four read beats and flags pending work
// ####################################################################

module ohci_ed_unpack import ohci_pkg::*; (
  input  logic        soc_clk_i,
  input  logic        rst_n_i,
  input  logic        beat_valid_i,
  input  logic [1:0]  beat_idx_i,
  input  logic [31:0] beat_data_i,
  output logic        ed_valid_o,
  output ed_t         ed_o,
  output logic        work_o
);

  logic    skip_q, halted_q;
  ed_ptr_t head_q, tail_q, next_q;

  // Word 0 sKip, word 1 TailP, word 2 HeadP with Halted, word 3 NextED
  always_ff @(posedge soc_clk_i) begin
    if (beat_valid_i) begin
      case (beat_idx_i)
        2'd0: skip_q <= beat_data_i[14];
        2'd1: tail_q <= beat_data_i[31:4];
        2'd2: begin
          head_q   <= beat_data_i[31:4];
          halted_q <= beat_data_i[0];
        end
        default: next_q <= beat_data_i[31:4];
      endcase
    end
  end

  // Pulse once the last word is stored
  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ed_valid_o <= 1'b0;
    end else begin
      ed_valid_o <= beat_valid_i && beat_idx_i == 2'd3;
    end
  end

  assign ed_o = '{skip: skip_q, halted: halted_q, head_ptr: head_q,
                  tail_ptr: tail_q, next_ed: next_q};

  // Empty queue when HeadP equals TailP
  assign work_o = !skip_q && !halted_q && (head_q != tail_q);

endmodule

// File: dma/ohci_dma_reader.sv
// ####################################################################
// AXI4-Lite read manager, fetches one ED as four single-word reads
// ####################################################################

module ohci_dma_reader import ohci_pkg::*; #(
  parameter int unsigned DmaAddrWidth = 32
) (
  input  logic                    soc_clk_i,
  input  logic                    rst_n_i,
  output logic                    dma_arvalid_o,
  input  logic                    dma_arready_i,
  output logic [DmaAddrWidth-1:0] dma_araddr_o,
  input  logic                    dma_rvalid_i,
  output logic                    dma_rready_o,
  input  logic [31:0]             dma_rdata_i,
  ohci_desc_if.responder          fetch
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  rd_state_e   state_q;
  ed_ptr_t     ptr_q;
  logic [1:0]  beat_q;
  logic [31:0] word_addr;
  logic        beat_fire;

  // Word address is pointer*16 plus beat*4
  assign word_addr       = {ptr_q, beat_q, 2'b00};
  assign dma_araddr_o    = DmaAddrWidth'(word_addr);
  assign dma_arvalid_o   = state_q == RD_ADDR;
  assign dma_rready_o    = state_q == RD_DATA;
  assign fetch.req_ready = state_q == RD_IDLE;
  assign beat_fire       = dma_rvalid_i && dma_rready_o;

  always_ff @(posedge soc_clk_i) begin
    if (fetch.req_valid && fetch.req_ready) begin
      ptr_q <= fetch.req_addr;
    end
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RD_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (fetch.req_valid) begin
            beat_q  <= '0;
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: if (dma_arready_i) state_q <= RD_DATA;
        RD_DATA: begin
          if (beat_fire) begin
            beat_q  <= beat_q + 2'd1;
            state_q <= (beat_q == 2'd3) ? RD_IDLE : RD_ADDR;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  ohci_ed_unpack i_ed_unpack (
    .soc_clk_i    ( soc_clk_i ),
    .rst_n_i      ( rst_n_i ),
    .beat_valid_i ( beat_fire ),
    .beat_idx_i   ( beat_q ),
    .beat_data_i  ( dma_rdata_i ),
    .ed_valid_o   ( fetch.rsp_valid ),
    .ed_o         ( fetch.rsp_ed ),
    .work_o       ( fetch.rsp_work )
  );

  a_ar_stable: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    dma_arvalid_o && !dma_arready_i |=> dma_arvalid_o && $stable(dma_araddr_o));

endmodule

// File: listservice/ohci_listservice.sv
// ####################################################################
// Control and bulk ED list walker, CBSR+1 control EDs per bulk ED
// ####################################################################

module ohci_listservice import ohci_pkg::*; (
  input  logic           soc_clk_i,
  input  logic           rst_n_i,
  input  reg2hw_t        reg2hw_i,
  output hw2reg_t        hw2reg_o,
  ohci_desc_if.requester fetch
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SELECT,
    ST_WAIT
  } state_e;

  state_e     state_q;
  logic       run_q;
  logic       ctrl_ex_q, bulk_ex_q;
  logic       sel_bulk_q;
  // Control EDs taken since the last bulk ED
  logic [2:0] ratio_cnt_q;
  logic       start, all_ex, take_bulk;

  assign start     = reg2hw_i.run && !run_q && state_q == ST_IDLE;
  assign all_ex    = ctrl_ex_q && bulk_ex_q;
  assign take_bulk = ctrl_ex_q || (!bulk_ex_q && ratio_cnt_q > {1'b0, reg2hw_i.cbsr});

  // Pointer comes straight from the current register, updated the cycle before
  assign fetch.req_valid = state_q == ST_SELECT && !all_ex;
  assign fetch.req_addr  = take_bulk ? reg2hw_i.bulk_cur : reg2hw_i.ctrl_cur;

  always_comb begin
    hw2reg_o = '0;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          hw2reg_o.ctrl_cur_de = reg2hw_i.cle;
          hw2reg_o.ctrl_cur_d  = reg2hw_i.ctrl_head;
          hw2reg_o.bulk_cur_de = reg2hw_i.ble;
          hw2reg_o.bulk_cur_d  = reg2hw_i.bulk_head;
        end
      end
      ST_SELECT: begin
        hw2reg_o.done_set = all_ex;
        hw2reg_o.run_clr  = all_ex;
      end
      ST_WAIT: begin
        if (fetch.rsp_valid) begin
          hw2reg_o.ctrl_cur_de  = !sel_bulk_q;
          hw2reg_o.ctrl_cur_d   = fetch.rsp_ed.next_ed;
          hw2reg_o.bulk_cur_de  = sel_bulk_q;
          hw2reg_o.bulk_cur_d   = fetch.rsp_ed.next_ed;
          hw2reg_o.serviced_inc = fetch.rsp_work;
        end
      end
      default: hw2reg_o = '0;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      run_q       <= 1'b0;
      ctrl_ex_q   <= 1'b1;
      bulk_ex_q   <= 1'b1;
      sel_bulk_q  <= 1'b0;
      ratio_cnt_q <= '0;
    end else begin
      run_q <= reg2hw_i.run;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            ctrl_ex_q   <= !reg2hw_i.cle || reg2hw_i.ctrl_head == '0;
            bulk_ex_q   <= !reg2hw_i.ble || reg2hw_i.bulk_head == '0;
            ratio_cnt_q <= '0;
            state_q     <= ST_SELECT;
          end
        end
        ST_SELECT: begin
          if (all_ex) begin
            state_q <= ST_IDLE;
          end else if (fetch.req_ready) begin
            sel_bulk_q <= take_bulk;
            state_q    <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (fetch.rsp_valid) begin
            if (sel_bulk_q) begin
              bulk_ex_q   <= fetch.rsp_ed.next_ed == '0;
              ratio_cnt_q <= '0;
            end else begin
              ctrl_ex_q <= fetch.rsp_ed.next_ed == '0;
              // saturates while the bulk list is exhausted
              if (ratio_cnt_q <= {1'b0, reg2hw_i.cbsr}) begin
                ratio_cnt_q <= ratio_cnt_q + 3'd1;
              end
            end
            state_q <= ST_SELECT;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  a_no_null_fetch: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    fetch.req_valid |-> fetch.req_addr != '0);

endmodule

// File: verilog/ohci_regs.sv
// ####################################################################
// OHCI register file on an AXI4-Lite subordinate port, with hardware
// update inputs and the DONE interrupt
// ####################################################################

module ohci_regs import ohci_pkg::*; (
  input  logic        soc_clk_i,
  input  logic        rst_n_i,
  input  logic        ctrl_awvalid_i,
  output logic        ctrl_awready_o,
  input  logic [31:0] ctrl_awaddr_i,
  input  logic        ctrl_wvalid_i,
  output logic        ctrl_wready_o,
  input  logic [31:0] ctrl_wdata_i,
  input  logic [3:0]  ctrl_wstrb_i,
  output logic        ctrl_bvalid_o,
  input  logic        ctrl_bready_i,
  output logic [1:0]  ctrl_bresp_o,
  input  logic        ctrl_arvalid_i,
  output logic        ctrl_arready_o,
  input  logic [31:0] ctrl_araddr_i,
  output logic        ctrl_rvalid_o,
  input  logic        ctrl_rready_i,
  output logic [31:0] ctrl_rdata_o,
  output logic [1:0]  ctrl_rresp_o,
  input  hw2reg_t     hw2reg_i,
  output reg2hw_t     reg2hw_o,
  output logic        intr_o
);

  logic        run_q, cle_q, ble_q, done_q, intr_en_q;
  logic [1:0]  cbsr_q;
  ed_ptr_t     ctrl_head_q, ctrl_cur_q, bulk_head_q, bulk_cur_q;
  logic [31:0] serviced_q;
  logic        wr_rdy_q;
  logic        wr_en, rd_en;
  logic [7:0]  wr_ofs;
  logic [31:0] strb_mask, wr_word;

  function automatic logic [31:0] reg_word(input logic [7:0] ofs);
    logic [31:0] word;
    word = '0;
    case (ofs)
      CTRL_OFS:      word = {26'd0, cbsr_q, 1'b0, ble_q, cle_q, run_q};
      STATUS_OFS:    word = {31'd0, done_q};
      CTRL_HEAD_OFS: word = {ctrl_head_q, 4'd0};
      CTRL_CUR_OFS:  word = {ctrl_cur_q, 4'd0};
      BULK_HEAD_OFS: word = {bulk_head_q, 4'd0};
      BULK_CUR_OFS:  word = {bulk_cur_q, 4'd0};
      INTR_EN_OFS:   word = {31'd0, intr_en_q};
      SERVICED_OFS:  word = serviced_q;
      default:       word = '0;
    endcase
    return word;
  endfunction

  // Both ready signals rise together once AW and W are present
  assign ctrl_awready_o = wr_rdy_q;
  assign ctrl_wready_o  = wr_rdy_q;
  assign wr_en  = wr_rdy_q && ctrl_awvalid_i && ctrl_wvalid_i;
  assign rd_en  = ctrl_arready_o && ctrl_arvalid_i;
  assign wr_ofs = ctrl_awaddr_i[7:0];
  assign ctrl_bresp_o = 2'b00;
  assign ctrl_rresp_o = 2'b00;

  // Byte strobes merge new data into the current word
  assign strb_mask = {{8{ctrl_wstrb_i[3]}}, {8{ctrl_wstrb_i[2]}},
                      {8{ctrl_wstrb_i[1]}}, {8{ctrl_wstrb_i[0]}}};
  assign wr_word   = (reg_word(wr_ofs) & ~strb_mask) | (ctrl_wdata_i & strb_mask);

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_rdy_q       <= 1'b0;
      ctrl_bvalid_o  <= 1'b0;
      ctrl_arready_o <= 1'b0;
      ctrl_rvalid_o  <= 1'b0;
    end else begin
      wr_rdy_q <= ctrl_awvalid_i && ctrl_wvalid_i && !wr_rdy_q && !ctrl_bvalid_o;
      if (wr_en) begin
        ctrl_bvalid_o <= 1'b1;
      end else if (ctrl_bready_i) begin
        ctrl_bvalid_o <= 1'b0;
      end
      ctrl_arready_o <= ctrl_arvalid_i && !ctrl_arready_o && !ctrl_rvalid_o;
      if (rd_en) begin
        ctrl_rvalid_o <= 1'b1;
      end else if (ctrl_rready_i) begin
        ctrl_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (rd_en) begin
      ctrl_rdata_o <= reg_word(ctrl_araddr_i[7:0]);
    end
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q       <= 1'b0;
      cle_q       <= 1'b0;
      ble_q       <= 1'b0;
      cbsr_q      <= '0;
      done_q      <= 1'b0;
      intr_en_q   <= 1'b0;
      ctrl_head_q <= '0;
      ctrl_cur_q  <= '0;
      bulk_head_q <= '0;
      bulk_cur_q  <= '0;
      serviced_q  <= '0;
    end else begin
      if (wr_en && wr_ofs == CTRL_OFS) begin
        cle_q  <= wr_word[1];
        ble_q  <= wr_word[2];
        cbsr_q <= wr_word[5:4];
      end
      // Hardware wins over software on RUN, DONE and the current pointers
      if (hw2reg_i.run_clr) begin
        run_q <= 1'b0;
      end else if (wr_en && wr_ofs == CTRL_OFS) begin
        run_q <= wr_word[0];
      end
      if (hw2reg_i.done_set) begin
        done_q <= 1'b1;
      end else if (wr_en && wr_ofs == STATUS_OFS && ctrl_wdata_i[0] && ctrl_wstrb_i[0]) begin
        done_q <= 1'b0;
      end
      if (hw2reg_i.ctrl_cur_de) begin
        ctrl_cur_q <= hw2reg_i.ctrl_cur_d;
      end else if (wr_en && wr_ofs == CTRL_CUR_OFS) begin
        ctrl_cur_q <= wr_word[31:4];
      end
      if (hw2reg_i.bulk_cur_de) begin
        bulk_cur_q <= hw2reg_i.bulk_cur_d;
      end else if (wr_en && wr_ofs == BULK_CUR_OFS) begin
        bulk_cur_q <= wr_word[31:4];
      end
      if (wr_en && wr_ofs == CTRL_HEAD_OFS) begin
        ctrl_head_q <= wr_word[31:4];
      end
      if (wr_en && wr_ofs == BULK_HEAD_OFS) begin
        bulk_head_q <= wr_word[31:4];
      end
      if (wr_en && wr_ofs == INTR_EN_OFS) begin
        intr_en_q <= wr_word[0];
      end
      // Count restarts when a new walk is launched
      if (wr_en && wr_ofs == CTRL_OFS && wr_word[0] && !run_q) begin
        serviced_q <= '0;
      end else if (hw2reg_i.serviced_inc) begin
        serviced_q <= serviced_q + 32'd1;
      end
    end
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      intr_o <= 1'b0;
    end else begin
      intr_o <= done_q && intr_en_q;
    end
  end

  assign reg2hw_o = '{run: run_q, cle: cle_q, ble: ble_q, cbsr: cbsr_q,
                      ctrl_head: ctrl_head_q, ctrl_cur: ctrl_cur_q,
                      bulk_head: bulk_head_q, bulk_cur: bulk_cur_q};

  a_bvalid_hold: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    ctrl_bvalid_o && !ctrl_bready_i |=> ctrl_bvalid_o);
  a_rvalid_hold: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    ctrl_rvalid_o && !ctrl_rready_i |=> ctrl_rvalid_o && $stable(ctrl_rdata_o));

endmodule

// File: verilog/ohci_top.sv
// ####################################################################
// OHCI list-service front end: register port, list walker, ED fetch
// ####################################################################

module ohci_top import ohci_pkg::*; #(
  parameter int unsigned DmaAddrWidth = 32
) (
  input  logic                    soc_clk_i,
  input  logic                    rst_n_i,
  // Register subordinate port
  input  logic                    ctrl_awvalid_i,
  output logic                    ctrl_awready_o,
  input  logic [31:0]             ctrl_awaddr_i,
  input  logic                    ctrl_wvalid_i,
  output logic                    ctrl_wready_o,
  input  logic [31:0]             ctrl_wdata_i,
  input  logic [3:0]              ctrl_wstrb_i,
  output logic                    ctrl_bvalid_o,
  input  logic                    ctrl_bready_i,
  output logic [1:0]              ctrl_bresp_o,
  input  logic                    ctrl_arvalid_i,
  output logic                    ctrl_arready_o,
  input  logic [31:0]             ctrl_araddr_i,
  output logic                    ctrl_rvalid_o,
  input  logic                    ctrl_rready_i,
  output logic [31:0]             ctrl_rdata_o,
  output logic [1:0]              ctrl_rresp_o,
  // DMA read manager port
  output logic                    dma_arvalid_o,
  input  logic                    dma_arready_i,
  output logic [DmaAddrWidth-1:0] dma_araddr_o,
  input  logic                    dma_rvalid_i,
  output logic                    dma_rready_o,
  input  logic [31:0]             dma_rdata_i,
  output logic                    intr_o
);

  reg2hw_t reg2hw;
  hw2reg_t hw2reg;

  ohci_desc_if fetch_if ();

  ohci_regs i_regs (
    .soc_clk_i, .rst_n_i,
    .ctrl_awvalid_i, .ctrl_awready_o, .ctrl_awaddr_i,
    .ctrl_wvalid_i, .ctrl_wready_o, .ctrl_wdata_i, .ctrl_wstrb_i,
    .ctrl_bvalid_o, .ctrl_bready_i, .ctrl_bresp_o,
    .ctrl_arvalid_i, .ctrl_arready_o, .ctrl_araddr_i,
    .ctrl_rvalid_o, .ctrl_rready_i, .ctrl_rdata_o, .ctrl_rresp_o,
    .hw2reg_i ( hw2reg ),
    .reg2hw_o ( reg2hw ),
    .intr_o
  );

  ohci_listservice i_listservice (
    .soc_clk_i, .rst_n_i,
    .reg2hw_i ( reg2hw ),
    .hw2reg_o ( hw2reg ),
    .fetch    ( fetch_if.requester )
  );

  ohci_dma_reader #(
    .DmaAddrWidth ( DmaAddrWidth )
  ) i_dma_reader (
    .soc_clk_i, .rst_n_i,
    .dma_arvalid_o, .dma_arready_i, .dma_araddr_o,
    .dma_rvalid_i, .dma_rready_o, .dma_rdata_i,
    .fetch ( fetch_if.responder )
  );

endmodule

// File: tests/tb_clk_gen.sv
// ####################################################################
// Testbench clock and reset source, period 10, reset for 8 cycles
// ####################################################################

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: tests/tb_axil_mem.sv
// ####################################################################
// AXI4-Lite read-only memory model with random stalls on AR and R,
// logs every accepted read address
// ####################################################################

module tb_axil_mem #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  input  logic [AddrWidth-1:0] araddr_i,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output logic [31:0]          rdata_o
);

  // 4 KiB of word storage, filled by the testbench
  logic [31:0]          mem_q [0:1023];
  logic [AddrWidth-1:0] addr_log [$];
  logic [AddrWidth-1:0] addr_q;
  logic                 busy_q;
  int unsigned          delay_q;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      addr_q    <= '0;
      busy_q    <= 1'b0;
      delay_q   <= 0;
    end else begin
      arready_o <= 1'b0;
      if (rvalid_o) begin
        if (rready_i) begin
          rvalid_o <= 1'b0;
          delay_q  <= $urandom_range(0, 4);
        end
      end else if (busy_q) begin
        // Read latency stall
        if (delay_q == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem_q[addr_q[11:2]];
          busy_q   <= 1'b0;
        end else begin
          delay_q <= delay_q - 1;
        end
      end else if (arvalid_i && !arready_o) begin
        if (delay_q == 0) begin
          arready_o <= 1'b1;
          addr_q    <= araddr_i;
          addr_log.push_back(araddr_i);
          busy_q    <= 1'b1;
          delay_q   <= $urandom_range(0, 4);
        end else begin
          delay_q <= delay_q - 1;
        end
      end
    end
  end

endmodule

// File: tests/ohci_tb.sv
// ####################################################################
// OHCI list-service testbench: builds ED lists in memory, runs walks
// and checks fetch order, counts, status and interrupt
// ####################################################################

module ohci_tb import ohci_pkg::*; ();

  localparam int ED_WORK  = 0;
  localparam int ED_SKIP  = 1;
  localparam int ED_HALT  = 2;
  localparam int ED_EMPTY = 3;
  localparam int REG_TIMEOUT  = 50;
  localparam int WALK_TIMEOUT = 5000;

  logic        clk, rst_n;
  logic        ctrl_awvalid, ctrl_awready, ctrl_wvalid, ctrl_wready;
  logic [31:0] ctrl_awaddr, ctrl_wdata, ctrl_araddr, ctrl_rdata;
  logic [3:0]  ctrl_wstrb;
  logic        ctrl_bvalid, ctrl_bready, ctrl_arvalid, ctrl_arready;
  logic        ctrl_rvalid, ctrl_rready;
  logic [1:0]  ctrl_bresp, ctrl_rresp;
  logic        dma_arvalid, dma_arready, dma_rvalid, dma_rready;
  logic [31:0] dma_araddr, dma_rdata;
  logic        intr_o;
  logic [31:0] ctrl_eds [$];
  logic [31:0] bulk_eds [$];
  logic [31:0] exp_q [$];
  int          ctrl_kind [$];
  int          bulk_kind [$];

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  ohci_top #(.DmaAddrWidth(32)) uut (
    .soc_clk_i(clk), .rst_n_i(rst_n),
    .ctrl_awvalid_i(ctrl_awvalid), .ctrl_awready_o(ctrl_awready), .ctrl_awaddr_i(ctrl_awaddr),
    .ctrl_wvalid_i(ctrl_wvalid), .ctrl_wready_o(ctrl_wready), .ctrl_wdata_i(ctrl_wdata),
    .ctrl_wstrb_i(ctrl_wstrb), .ctrl_bvalid_o(ctrl_bvalid), .ctrl_bready_i(ctrl_bready),
    .ctrl_bresp_o(ctrl_bresp), .ctrl_arvalid_i(ctrl_arvalid), .ctrl_arready_o(ctrl_arready),
    .ctrl_araddr_i(ctrl_araddr), .ctrl_rvalid_o(ctrl_rvalid), .ctrl_rready_i(ctrl_rready),
    .ctrl_rdata_o(ctrl_rdata), .ctrl_rresp_o(ctrl_rresp),
    .dma_arvalid_o(dma_arvalid), .dma_arready_i(dma_arready), .dma_araddr_o(dma_araddr),
    .dma_rvalid_i(dma_rvalid), .dma_rready_o(dma_rready), .dma_rdata_i(dma_rdata),
    .intr_o(intr_o)
  );

  tb_axil_mem #(.AddrWidth(32)) i_mem (
    .clk_i(clk), .rst_n_i(rst_n),
    .arvalid_i(dma_arvalid), .arready_o(dma_arready), .araddr_i(dma_araddr),
    .rvalid_o(dma_rvalid), .rready_i(dma_rready), .rdata_o(dma_rdata)
  );

  task automatic stop_run(input string why);
    $display("*** TEST FAILED ***");
    $fatal(1, why);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
      stop_run("value mismatch");
    end
  endtask

  a_dma_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dma_arvalid && !dma_arready |=> dma_arvalid)
    else begin
      $display("FAIL t=%0t dma_arvalid exp=1 got=%b", $time, dma_arvalid);
      stop_run("DMA manager dropped arvalid before arready");
    end

  task automatic reg_write(input logic [7:0] ofs, input logic [31:0] data);
    int cnt;
    cnt = 0;
    @(posedge clk);
    ctrl_awvalid <= 1'b1;
    ctrl_awaddr  <= {24'd0, ofs};
    ctrl_wvalid  <= 1'b1;
    ctrl_wdata   <= data;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > REG_TIMEOUT) stop_run("timeout waiting for register write to be accepted");
    end while (!ctrl_awready);
    check_value("ctrl_wready", 32'd1, 32'(ctrl_wready));
    ctrl_awvalid <= 1'b0;
    ctrl_wvalid  <= 1'b0;
    cnt = 0;
    // Response waits with bready low for at least one edge
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > REG_TIMEOUT) stop_run("timeout waiting for register write response");
    end while (!ctrl_bvalid);
    check_value("ctrl_bresp", 32'd0, 32'(ctrl_bresp));
    ctrl_bready <= 1'b1;
    @(posedge clk);
    ctrl_bready <= 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] ofs, output logic [31:0] data);
    int cnt;
    cnt = 0;
    @(posedge clk);
    ctrl_arvalid <= 1'b1;
    ctrl_araddr  <= {24'd0, ofs};
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > REG_TIMEOUT) stop_run("timeout waiting for register read to be accepted");
    end while (!ctrl_arready);
    ctrl_arvalid <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > REG_TIMEOUT) stop_run("timeout waiting for register read data");
    end while (!ctrl_rvalid);
    data = ctrl_rdata;
    check_value("ctrl_rresp", 32'd0, 32'(ctrl_rresp));
    ctrl_rready <= 1'b1;
    @(posedge clk);
    ctrl_rready <= 1'b0;
  endtask

  task automatic check_reg(input string name, input logic [7:0] ofs, input logic [31:0] exp);
    logic [31:0] got;
    reg_read(ofs, got);
    check_value(name, exp, got);
  endtask

  task automatic wait_intr(input logic level);
    int cnt;
    cnt = 0;
    while (intr_o !== level) begin
      @(posedge clk);
      cnt++;
      if (cnt > WALK_TIMEOUT) stop_run("timeout waiting for intr_o to change");
    end
  endtask

  // Word 0 sKip, word 1 TailP, word 2 HeadP with Halted, word 3 NextED
  task automatic place_list(input logic [31:0] eds[$], input int kinds[$]);
    logic [31:0] nxt, tail;
    for (int i = 0; i < eds.size(); i++) begin
      nxt  = (i + 1 < eds.size()) ? eds[i+1] : 32'd0;
      tail = eds[i] + 32'h800;
      i_mem.mem_q[eds[i][11:2]]     = (kinds[i] == ED_SKIP) ? 32'h0000_4805 : 32'h0000_0805;
      i_mem.mem_q[eds[i][11:2] + 1] = tail;
      i_mem.mem_q[eds[i][11:2] + 2] = ((kinds[i] == ED_EMPTY) ? tail : tail + 32'h10)
                                      | ((kinds[i] == ED_HALT) ? 32'd1 : 32'd0);
      i_mem.mem_q[eds[i][11:2] + 3] = nxt;
    end
  endtask

  function automatic int count_work(input int kinds[$]);
    int n;
    n = 0;
    foreach (kinds[i]) begin
      if (kinds[i] == ED_WORK) n++;
    end
    return n;
  endfunction

  // CBSR+1 control EDs, then one bulk ED, the other list alone once one runs dry
  task automatic predict_order(input int cbsr, input bit use_ctrl, input bit use_bulk);
    int  ci, bi, run_len;
    bit  ctrl_left, bulk_left;
    ci = 0;
    bi = 0;
    run_len = 0;
    exp_q.delete();
    forever begin
      ctrl_left = use_ctrl && ci < ctrl_eds.size();
      bulk_left = use_bulk && bi < bulk_eds.size();
      if (!ctrl_left && !bulk_left) break;
      if (ctrl_left && (!bulk_left || run_len <= cbsr)) begin
        exp_q.push_back(ctrl_eds[ci]);
        ci++;
        run_len++;
      end else begin
        exp_q.push_back(bulk_eds[bi]);
        bi++;
        run_len = 0;
      end
    end
  endtask

  task automatic check_fetch_log();
    check_value("fetch_count", 32'(4 * exp_q.size()), 32'(i_mem.addr_log.size()));
    for (int k = 0; k < exp_q.size(); k++) begin
      for (int j = 0; j < 4; j++) begin
        check_value("dma_araddr", exp_q[k] + 32'(4 * j), i_mem.addr_log[4*k+j]);
      end
    end
  endtask

  task automatic wait_reset();
    int cnt;
    cnt = 0;
    while (!rst_n) begin
      @(posedge clk);
      cnt++;
      if (cnt > 50) stop_run("reset never released");
    end
  endtask

  initial begin
    void'($urandom(32'h29de_19df));
    ctrl_awvalid = 1'b0;
    ctrl_awaddr  = '0;
    ctrl_wvalid  = 1'b0;
    ctrl_wdata   = '0;
    ctrl_wstrb   = 4'hF;
    ctrl_bready  = 1'b0;
    ctrl_arvalid = 1'b0;
    ctrl_araddr  = '0;
    ctrl_rready  = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      i_mem.mem_q[i] = {16'hC0DE, 6'd0, i[9:0]};
    end
    // Control list linked out of address order
    ctrl_eds  = '{32'h200, 32'h2C0, 32'h240, 32'h280};
    ctrl_kind = '{ED_WORK, ED_SKIP, ED_HALT, ED_WORK};
    bulk_eds  = '{32'h400, 32'h480};
    bulk_kind = '{ED_EMPTY, ED_WORK};
    place_list(ctrl_eds, ctrl_kind);
    place_list(bulk_eds, bulk_kind);
    wait_reset();

    check_value("intr_o", 32'd0, 32'(intr_o));
    for (int ofs = 0; ofs < 32; ofs += 4) begin
      check_reg("reset_reg", 8'(ofs), 32'd0);
    end
    reg_write(CTRL_HEAD_OFS, 32'h200);
    reg_write(BULK_HEAD_OFS, 32'h400);
    reg_write(INTR_EN_OFS, 32'd1);
    reg_write(CTRL_OFS, 32'h10);
    check_reg("ctrl_head", CTRL_HEAD_OFS, 32'h200);
    check_reg("bulk_head", BULK_HEAD_OFS, 32'h400);
    check_reg("intr_en", INTR_EN_OFS, 32'd1);
    check_reg("ctrl", CTRL_OFS, 32'h10);

    // Full walk, CBSR=1, both lists
    predict_order(1, 1'b1, 1'b1);
    reg_write(CTRL_OFS, 32'h17);
    wait_intr(1'b1);
    check_fetch_log();
    check_reg("serviced", SERVICED_OFS, 32'(count_work(ctrl_kind) + count_work(bulk_kind)));
    check_reg("status", STATUS_OFS, 32'd1);
    check_reg("ctrl", CTRL_OFS, 32'h16);
    check_reg("ctrl_cur", CTRL_CUR_OFS, 32'd0);
    check_reg("bulk_cur", BULK_CUR_OFS, 32'd0);
    reg_write(STATUS_OFS, 32'd1);
    wait_intr(1'b0);
    check_reg("status", STATUS_OFS, 32'd0);

    // Control list only
    i_mem.addr_log.delete();
    predict_order(1, 1'b1, 1'b0);
    reg_write(CTRL_OFS, 32'h13);
    wait_intr(1'b1);
    check_fetch_log();
    check_reg("serviced", SERVICED_OFS, 32'(count_work(ctrl_kind)));
    check_reg("ctrl", CTRL_OFS, 32'h12);
    check_reg("ctrl_cur", CTRL_CUR_OFS, 32'd0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: all.f
common/ohci_pkg.sv
common/ohci_desc_if.sv
dma/ohci_ed_unpack.sv
dma/ohci_dma_reader.sv
listservice/ohci_listservice.sv
verilog/ohci_regs.sv
verilog/ohci_top.sv
tests/tb_clk_gen.sv
tests/tb_axil_mem.sv
tests/ohci_tb.sv

// File: build.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module ohci_tb -f all.f -o ohci_sim \
  && ./obj_dir/ohci_sim \
  || exit 1
